// File: verilog/lb_pkg.sv
// Local bus definitions shared by every stage of the reset block
// Single clock domain, no byte enables, no error response
// A request is a one-cycle strobe, wr_en and rd_en never high together
// Address splits into a 4-bit block field and an 8-bit register offset
package lb_pkg;

  // Bus widths
  localparam int unsigned LB_DATA_W = 32;
  localparam int unsigned LB_ADDR_W = 12;

  // Address fields, block in bits 11..8, offset in bits 7..0
  localparam int unsigned LB_BLK_W  = 4;
  localparam int unsigned LB_OFS_W  = 8;

  // Raw request as seen on the bus pins
  typedef struct packed {
    logic                 wr_en;
    logic                 rd_en;
    logic [LB_ADDR_W-1:0] addr;
    logic [LB_DATA_W-1:0] wr_data;
  } lb_req_t;

  // Request after the decode stage
  // blk_hit flags the reset block, mapped adds a legal offset and access
  typedef struct packed {
    logic                 wr_en;
    logic                 rd_en;
    logic                 mapped;
    logic                 blk_hit;
    logic [LB_OFS_W-1:0]  ofs;
    logic [LB_DATA_W-1:0] wr_data;
  } lb_dec_t;

  // Response, one valid pulse per strobe
  typedef struct packed {
    logic                 wr_valid;
    logic                 rd_valid;
    logic [LB_DATA_W-1:0] rd_data;
  } lb_rsp_t;

endpackage

// File: verilog/rst_pkg.sv
// Reset controller sizes and register map
// NUM_RESETS may be set from 1 to 32, nothing else here should change
// Control bit at 1 releases the block, at 0 holds it in reset
// SET and CLR are write only, STATUS is read only
package rst_pkg;

  // Number of downstream reset outputs
  localparam int unsigned NUM_RESETS = 4;

  // Block number of the reset controller in the address map
  localparam logic [lb_pkg::LB_BLK_W-1:0] RST_BLK = 4'd0;

  // Register offsets within the block
  localparam logic [lb_pkg::LB_OFS_W-1:0] RST_CTRL_OFS = 8'h00;
  localparam logic [lb_pkg::LB_OFS_W-1:0] RST_SET_OFS  = 8'h04;
  localparam logic [lb_pkg::LB_OFS_W-1:0] RST_CLR_OFS  = 8'h08;
  localparam logic [lb_pkg::LB_OFS_W-1:0] RST_STAT_OFS = 8'h0C;

  // Read word for unmapped or write-only locations
  localparam logic [lb_pkg::LB_DATA_W-1:0] DEFAULT_REG_VAL = 32'hDEADBABE;

endpackage

// File: verilog/lb_decode.sv
// First bus stage, registers each strobe and decodes the address
// Only the reset controller block is mapped, all other blocks are holes
// Access type is checked here, so a read of SET counts as unmapped
// One cycle of latency, no back-pressure
module lb_decode (
  input  logic            clk,
  input  logic            rst_n,
  input  lb_pkg::lb_req_t req,
  output lb_pkg::lb_dec_t dec
);

  import lb_pkg::*;
  import rst_pkg::*;

  logic [LB_BLK_W-1:0]  blk;
  logic [LB_OFS_W-1:0]  ofs;
  logic                 blk_hit;
  logic                 ofs_ok;

  // Registered request
  logic                 wr_q;
  logic                 rd_q;
  logic                 mapped_q;
  logic                 blk_hit_q;
  logic [LB_OFS_W-1:0]  ofs_q;
  logic [LB_DATA_W-1:0] wr_data_q;

  // Address split
  assign blk     = req.addr[LB_ADDR_W-1 -: LB_BLK_W];
  assign ofs     = req.addr[LB_OFS_W-1:0];
  assign blk_hit = (blk == RST_BLK);

  // Legal offset and access kind
  always_comb
  begin
    case (ofs)
      RST_CTRL_OFS: ofs_ok = 1'b1;
      RST_SET_OFS:  ofs_ok = req.wr_en;
      RST_CLR_OFS:  ofs_ok = req.wr_en;
      RST_STAT_OFS: ofs_ok = req.rd_en;
      default:      ofs_ok = 1'b0;
    endcase
  end

  // Strobes and qualifiers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
      mapped_q  <= 1'b0;
      blk_hit_q <= 1'b0;
    end
    else
    begin
      wr_q      <= req.wr_en;
      rd_q      <= req.rd_en;
      mapped_q  <= blk_hit & ofs_ok;
      blk_hit_q <= blk_hit;
    end
  end

  // Payload, only meaningful with a strobe
  always_ff @(posedge clk)
  begin
    ofs_q     <= ofs;
    wr_data_q <= req.wr_data;
  end

  assign dec = '{wr_en: wr_q, rd_en: rd_q, mapped: mapped_q, blk_hit: blk_hit_q,
                 ofs: ofs_q, wr_data: wr_data_q};

endmodule

// File: verilog/rst_cntrl.sv
// Reset control registers, CTRL, SET, CLR and STATUS
// Raw reset bits are active low and all held in reset after rst_n
// Valid pulses for every strobe aimed at this block, mapped or not
// Unmapped offsets are answered by the result stage, not here
// rd_data is only updated on a mapped read
module rst_cntrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  lb_pkg::lb_dec_t                dec,
  input  logic [rst_pkg::NUM_RESETS-1:0] blk_rst_n,
  output lb_pkg::lb_rsp_t                rsp,
  output logic [rst_pkg::NUM_RESETS-1:0] rst_raw_n
);

  import lb_pkg::*;
  import rst_pkg::*;

  logic [NUM_RESETS-1:0] ctrl_q;
  logic [NUM_RESETS-1:0] wr_bits;
  logic [LB_DATA_W-1:0]  ctrl_ext;
  logic [LB_DATA_W-1:0]  stat_ext;
  logic                  wr_valid_q;
  logic                  rd_valid_q;
  logic [LB_DATA_W-1:0]  rd_data_q;

  assign wr_bits = dec.wr_data[NUM_RESETS-1:0];

  // Zero extension, also safe at NUM_RESETS of 32
  always_comb
  begin
    ctrl_ext = '0;
    stat_ext = '0;
    ctrl_ext[NUM_RESETS-1:0] = ctrl_q;
    stat_ext[NUM_RESETS-1:0] = blk_rst_n;
  end

  // Control vector and valid pulses
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_q     <= '0;
      wr_valid_q <= 1'b0;
      rd_valid_q <= 1'b0;
    end
    else
    begin
      if (dec.wr_en && dec.mapped)
      begin
        case (dec.ofs)
          RST_CTRL_OFS: ctrl_q <= wr_bits;
          RST_SET_OFS:  ctrl_q <= ctrl_q | wr_bits;
          RST_CLR_OFS:  ctrl_q <= ctrl_q & ~wr_bits;
          default:      ctrl_q <= ctrl_q;
        endcase
      end
      wr_valid_q <= dec.wr_en & dec.blk_hit;
      rd_valid_q <= dec.rd_en & dec.blk_hit;
    end
  end

  // Read data, status reflects the synchronized outputs
  always_ff @(posedge clk)
  begin
    if (dec.rd_en && dec.mapped)
    begin
      case (dec.ofs)
        RST_CTRL_OFS: rd_data_q <= ctrl_ext;
        RST_STAT_OFS: rd_data_q <= stat_ext;
        default:      rd_data_q <= DEFAULT_REG_VAL;
      endcase
    end
  end

  assign rsp = '{wr_valid: wr_valid_q, rd_valid: rd_valid_q, rd_data: rd_data_q};

  // Raw resets follow the control vector directly
  assign rst_raw_n = ctrl_q;

endmodule

// File: verilog/rst_sync_bank.sv
// Per-block reset synchronizers on the single clk domain
// Assert is immediate, from rst_n or a low raw bit
// Deassert takes two clk edges after both are high
module rst_sync_bank (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [rst_pkg::NUM_RESETS-1:0] rst_raw_n,
  output logic [rst_pkg::NUM_RESETS-1:0] blk_rst_n
);

  import rst_pkg::*;

  for (genvar i = 0; i < NUM_RESETS; i++)
  begin : g_sync
    logic       clr_n;
    logic [1:0] sync_q;

    // Either source holds this block in reset
    assign clr_n = rst_n & rst_raw_n[i];

    // Chain fills with 1s once the clear is gone
    always_ff @(posedge clk or negedge clr_n)
    begin
      if (!clr_n)
      begin
        sync_q <= 2'b00;
      end
      else
      begin
        sync_q <= {sync_q[0], 1'b1};
      end
    end

    // Low while clr_n is low, thanks to the async clear
    assign blk_rst_n[i] = sync_q[1];
  end

endmodule

// File: verilog/lb_rsp_mux.sv
// Result stage, merges the reset block response with the default answer
// Unmapped strobes get a valid pulse here, reads return DEFAULT_REG_VAL
// Output is registered, rd_data holds between reads
module lb_rsp_mux (
  input  logic            clk,
  input  logic            rst_n,
  input  lb_pkg::lb_dec_t dec,
  input  lb_pkg::lb_rsp_t rsp_in,
  output lb_pkg::lb_rsp_t rsp
);

  import lb_pkg::*;
  import rst_pkg::*;

  // Decoded strobe delayed to line up with rsp_in
  logic                 dly_wr;
  logic                 dly_rd;
  logic                 dly_mapped;
  logic                 dly_unmapped;

  logic                 wr_valid_q;
  logic                 rd_valid_q;
  logic [LB_DATA_W-1:0] rd_data_q;

  assign dly_unmapped = (dly_wr | dly_rd) & ~dly_mapped;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dly_wr     <= 1'b0;
      dly_rd     <= 1'b0;
      dly_mapped <= 1'b0;
      wr_valid_q <= 1'b0;
      rd_valid_q <= 1'b0;
      rd_data_q  <= '0;
    end
    else
    begin
      dly_wr     <= dec.wr_en;
      dly_rd     <= dec.rd_en;
      dly_mapped <= dec.mapped;

      if (dly_unmapped)
      begin
        // Default answer overrides any blk_hit response
        wr_valid_q <= dly_wr;
        rd_valid_q <= dly_rd;
        if (dly_rd)
        begin
          rd_data_q <= DEFAULT_REG_VAL;
        end
      end
      else
      begin
        wr_valid_q <= rsp_in.wr_valid;
        rd_valid_q <= rsp_in.rd_valid;
        if (rsp_in.rd_valid)
        begin
          rd_data_q <= rsp_in.rd_data;
        end
      end
    end
  end

  assign rsp = '{wr_valid: wr_valid_q, rd_valid: rd_valid_q, rd_data: rd_data_q};

endmodule

// File: verilog/sys_rst_top.sv
// Software reset subsystem, local bus in, per-block resets out
// Fixed bus latency of 3 cycles, up to 3 requests in flight
// Only block 0 is mapped, everything else reads DEFAULT_REG_VAL
// Released resets reach blk_rst_n two edges after the raw bit
module sys_rst_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lb_wr_en,
  input  logic                           lb_rd_en,
  input  logic [lb_pkg::LB_ADDR_W-1:0]   lb_addr,
  input  logic [lb_pkg::LB_DATA_W-1:0]   lb_wr_data,
  output logic                           lb_wr_valid,
  output logic                           lb_rd_valid,
  output logic [lb_pkg::LB_DATA_W-1:0]   lb_rd_data,
  output logic [rst_pkg::NUM_RESETS-1:0] blk_rst_n
);

  import lb_pkg::*;
  import rst_pkg::*;

  lb_req_t               bus_req;
  lb_dec_t               bus_dec;
  lb_rsp_t               cntrl_rsp;
  lb_rsp_t               bus_rsp;
  logic [NUM_RESETS-1:0] rst_raw_n;

  // Pins into the request struct
  assign bus_req = '{wr_en: lb_wr_en, rd_en: lb_rd_en, addr: lb_addr, wr_data: lb_wr_data};

  lb_decode u_lb_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (bus_req),
    .dec   (bus_dec)
  );

  rst_cntrl u_rst_cntrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (bus_dec),
    .blk_rst_n (blk_rst_n),
    .rsp       (cntrl_rsp),
    .rst_raw_n (rst_raw_n)
  );

  rst_sync_bank u_rst_sync_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .rst_raw_n (rst_raw_n),
    .blk_rst_n (blk_rst_n)
  );

  lb_rsp_mux u_lb_rsp_mux (
    .clk    (clk),
    .rst_n  (rst_n),
    .dec    (bus_dec),
    .rsp_in (cntrl_rsp),
    .rsp    (bus_rsp)
  );

  // Response struct back onto the pins
  assign lb_wr_valid = bus_rsp.wr_valid;
  assign lb_rd_valid = bus_rsp.rd_valid;
  assign lb_rd_data  = bus_rsp.rd_data;

endmodule

// File: verif/sys_rst_properties.sv
// Bus timing and reset output checks, bound to sys_rst_top
// Assumes the fixed 3-cycle bus latency and no strobes during reset
module sys_rst_properties (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           lb_wr_en,
  input logic                           lb_rd_en,
  input logic                           lb_wr_valid,
  input logic                           lb_rd_valid,
  input logic [rst_pkg::NUM_RESETS-1:0] rst_raw_n,
  input logic [rst_pkg::NUM_RESETS-1:0] blk_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Assertion failures so far
  int fail_count = 0;

  // Each strobe answered 3 cycles later, same kind
  a_wr_latency: assert property (@(posedge clk) disable iff (!rst_n) lb_wr_en |-> ##3 lb_wr_valid)
    else
    begin
      $error("write strobe not answered by a write valid 3 cycles later");
      fail_count++;
    end
  a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n) lb_rd_en |-> ##3 lb_rd_valid)
    else
    begin
      $error("read strobe not answered by a read valid 3 cycles later");
      fail_count++;
    end

  a_one_valid: assert property (@(posedge clk) disable iff (!rst_n) !(lb_wr_valid && lb_rd_valid))
    else
    begin
      $error("write valid and read valid high together");
      fail_count++;
    end

  // All blocks held while the global reset is low
  a_rst_hold: assert property (@(posedge clk) !rst_n |-> (blk_rst_n == '0))
    else
    begin
      $error("blk_rst_n not all low during reset");
      fail_count++;
    end

  // No release right after a low raw bit
  a_no_early_release: assert property (@(posedge clk) disable iff (!rst_n)
    (blk_rst_n & ~$past(blk_rst_n) & ~$past(rst_raw_n)) == '0)
    else
    begin
      $error("blk_rst_n rose one cycle after its raw bit was low");
      fail_count++;
    end

endmodule

bind sys_rst_top sys_rst_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .lb_wr_en    (lb_wr_en),
  .lb_rd_en    (lb_rd_en),
  .lb_wr_valid (lb_wr_valid),
  .lb_rd_valid (lb_rd_valid),
  .rst_raw_n   (rst_raw_n),
  .blk_rst_n   (blk_rst_n)
);

// File: verif/sys_rst_tb.sv
// Testbench for sys_rst_top, stimulus from verif/sys_rst_tests.txt
// Run from the project root so the test file path resolves
// Expected words in the file assume NUM_RESETS of 4
// Lower case op letters chain the next line onto the very next cycle
// Then 16 random CTRL writes with readback, LCG seed 81
module sys_rst_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lb_pkg::*;
  import rst_pkg::*;

  // One bus operation and what it should return
  typedef struct packed {
    logic        is_rd;
    logic        from_file;
    logic [31:0] id;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
  } op_t;

  logic                  clk;
  logic                  rst_n;
  logic                  lb_wr_en;
  logic                  lb_rd_en;
  logic [LB_ADDR_W-1:0]  lb_addr;
  logic [LB_DATA_W-1:0]  lb_wr_data;
  logic                  lb_wr_valid;
  logic                  lb_rd_valid;
  logic [LB_DATA_W-1:0]  lb_rd_data;
  logic [NUM_RESETS-1:0] blk_rst_n;

  // Reference model of the control vector
  logic [NUM_RESETS-1:0] model_ctrl;
  logic                  wrote;

  op_t  file_ops[$];
  logic chain_q[$];
  op_t  pend_q[$];
  int   errors;
  int   checks;
  int   tests_done;
  int   tests_failed;
  int   test_id;
  int   cycles;
  int   cycle_limit;

  sys_rst_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .lb_wr_en    (lb_wr_en),
    .lb_rd_en    (lb_rd_en),
    .lb_addr     (lb_addr),
    .lb_wr_data  (lb_wr_data),
    .lb_wr_valid (lb_wr_valid),
    .lb_rd_valid (lb_rd_valid),
    .lb_rd_data  (lb_rd_data),
    .blk_rst_n   (blk_rst_n)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit from the test count
  always @(posedge clk)
  begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] to_word(input logic [NUM_RESETS-1:0] v);
    logic [31:0] w;
    w = '0;
    w[NUM_RESETS-1:0] = v;
    return w;
  endfunction

  // Status assumed settled, reads of anything else give the default word
  function automatic logic [31:0] predict_read(input logic [11:0] addr);
    if (addr[11:8] == RST_BLK && (addr[7:0] == RST_CTRL_OFS || addr[7:0] == RST_STAT_OFS))
      return to_word(model_ctrl);
    return DEFAULT_REG_VAL;
  endfunction

  function automatic void apply_write(input logic [11:0] addr, input logic [31:0] data);
    if (addr[11:8] == RST_BLK && addr[7:0] == RST_CTRL_OFS)
      model_ctrl = data[NUM_RESETS-1:0];
    else if (addr[11:8] == RST_BLK && addr[7:0] == RST_SET_OFS)
      model_ctrl = model_ctrl | data[NUM_RESETS-1:0];
    else if (addr[11:8] == RST_BLK && addr[7:0] == RST_CLR_OFS)
      model_ctrl = model_ctrl & ~data[NUM_RESETS-1:0];
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic load_tests(output logic ok);
    int          fd;
    int          rc;
    string       line;
    logic [7:0]  op;
    logic [31:0] a32;
    logic [31:0] d32;
    logic [31:0] e32;
    op_t         ent;
    ok = 1'b0;
    fd = $fopen("verif/sys_rst_tests.txt", "r");
    if (fd == 0)
      return;
    ok = 1'b1;
    while ($feof(fd) == 0)
    begin
      line = "";
      rc = $fgets(line, fd);
      // Skip comments and blank lines
      if (rc > 0 && line.len() > 0 && line.getc(0) != "#")
      begin
        rc = $sscanf(line, "%c %h %h %h", op, a32, d32, e32);
        if (rc == 4 && (op == "W" || op == "w" || op == "R" || op == "r"))
        begin
          ent = '{is_rd: (op == "R" || op == "r"), from_file: 1'b1, id: 32'd0,
                  addr: a32[11:0], wdata: d32, exp: e32};
          file_ops.push_back(ent);
          chain_q.push_back(op == "w" || op == "r");
        end
      end
    end
    $fclose(fd);
  endtask

  // Sample one response after the edge, responses come back in issue order
  task automatic collect_rsp();
    op_t ent;
    int  e0;
    if (lb_wr_valid || lb_rd_valid)
    begin
      if (pend_q.size() == 0)
      begin
        errors++;
        $display("ERROR: valid pulse with no request outstanding");
      end
      else
      begin
        ent = pend_q.pop_front();
        e0 = errors;
        if (ent.is_rd != lb_rd_valid)
        begin
          errors++;
          $display("ERROR: test %0d got a valid pulse of the wrong kind", ent.id);
        end
        else if (ent.is_rd)
        begin
          if (ent.from_file)
            check_val("lb_rd_data", ent.exp, lb_rd_data);
          check_val("lb_rd_data(model)", predict_read(ent.addr), lb_rd_data);
        end
        else
        begin
          apply_write(ent.addr, ent.wdata);
          wrote = 1'b1;
          // Cleared blocks must already be in reset
          check_val("blk_rst_n", 32'h0, to_word(blk_rst_n & ~model_ctrl));
        end
        tests_done++;
        if (errors != e0)
          tests_failed++;
        $display("test %0d %s addr 0x%03h %s", ent.id, ent.is_rd ? "read " : "write",
                 ent.addr, (errors == e0) ? "ok" : "failed");
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    collect_rsp();
    lb_wr_en = 1'b0;
    lb_rd_en = 1'b0;
  endtask

  task automatic issue(input op_t op);
    op_t ent;
    ent = op;
    ent.id = test_id;
    test_id++;
    lb_wr_en   = ~op.is_rd;
    lb_rd_en   = op.is_rd;
    lb_addr    = op.addr;
    lb_wr_data = op.wdata;
    pend_q.push_back(ent);
    next_cycle();
  endtask

  // Wait out all pending responses, then let released resets settle
  task automatic drain();
    int waited;
    waited = 0;
    while (pend_q.size() > 0 && waited < 8)
    begin
      next_cycle();
      waited++;
    end
    if (pend_q.size() > 0)
    begin
      $display("ERROR: %0d requests got no valid pulse, from test %0d on",
               pend_q.size(), pend_q[0].id);
      errors += pend_q.size();
      tests_failed += pend_q.size();
      pend_q.delete();
    end
    if (wrote)
    begin
      next_cycle();
      next_cycle();
      check_val("blk_rst_n", to_word(model_ctrl), to_word(blk_rst_n));
      wrote = 1'b0;
    end
  endtask

  initial
  begin
    logic        ok;
    op_t         op;
    logic [31:0] seed;
    lb_wr_en   = 1'b0;
    lb_rd_en   = 1'b0;
    lb_addr    = '0;
    lb_wr_data = '0;
    rst_n      = 1'b0;
    model_ctrl = '0;
    wrote      = 1'b0;
    load_tests(ok);
    cycle_limit = (file_ops.size() + 32) * 8 + 16 + 100;
    if (!ok)
    begin
      errors++;
      $display("ERROR: could not open verif/sys_rst_tests.txt");
    end
    repeat (16) @(posedge clk);
    #1;
    check_val("blk_rst_n", 32'h0, to_word(blk_rst_n));
    rst_n = 1'b1;
    next_cycle();
    next_cycle();
    check_val("blk_rst_n", 32'h0, to_word(blk_rst_n));
    foreach (file_ops[i])
    begin
      issue(file_ops[i]);
      if (!chain_q[i])
        drain();
    end
    drain();
    // Random CTRL values, each read back
    seed = 32'd81;
    repeat (16)
    begin
      seed = lcg_next(seed);
      op = '{is_rd: 1'b0, from_file: 1'b0, id: 32'd0, addr: {RST_BLK, RST_CTRL_OFS},
             wdata: seed, exp: 32'd0};
      issue(op);
      drain();
      op.is_rd = 1'b1;
      issue(op);
      drain();
    end
    // Let the last latency properties complete, no stray pulses expected
    next_cycle();
    next_cycle();
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_done, tests_failed, checks, errors, UUT.u_props.fail_count);
    if (errors == 0 && tests_done == test_id && UUT.u_props.fail_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verif/sys_rst_tests.txt
# op addr data expect, all hex, expect is only checked on reads
# W/R waits for the response, w/r chains the next line on the next cycle
R 000 00000000 00000000
R 00C 00000000 00000000
W 000 0000000A 00000000
R 000 00000000 0000000A
R 00C 00000000 0000000A
W 000 FFFFFFF5 00000000
R 000 00000000 00000005
W 004 00000008 00000000
R 000 00000000 0000000D
W 008 00000001 00000000
R 000 00000000 0000000C
R 00C 00000000 0000000C
R 004 00000000 DEADBABE
R 008 00000000 DEADBABE
R 010 00000000 DEADBABE
R 100 00000000 DEADBABE
R F0C 00000000 DEADBABE
W 010 0000000F 00000000
W 100 00000003 00000000
W 00C 0000000F 00000000
R 000 00000000 0000000C
w 004 00000003 00000000
r 000 00000000 0000000F
w 008 00000004 00000000
R 000 00000000 0000000B
R 00C 00000000 0000000B
r 00C 00000000 0000000B
r 004 00000000 DEADBABE
R 200 00000000 DEADBABE

// File: src.f
verilog/lb_pkg.sv
verilog/rst_pkg.sv
verilog/lb_decode.sv
verilog/rst_cntrl.sv
verilog/rst_sync_bank.sv
verilog/lb_rsp_mux.sv
verilog/sys_rst_top.sv
verif/sys_rst_properties.sv
verif/sys_rst_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
  --top-module sys_rst_tb -o sys_rst_sim > build.log 2>&1 \
  && ./obj_dir/sys_rst_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log and sim.log"
grep -qs "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
